//--- common/d0Settings_settings.svh
/*
 * Sound glue chip settings
 * Divider ratios, latch field widths and the work RAM base
 */
`ifndef D0_SETTINGS_SVH
`define D0_SETTINGS_SVH

// Bank register width on the main CPU side
`define D0_BANK_W 3

// Width of one of the two port outputs
`define D0_PORT_W 3

// 24 MHz positive ticks per 6 MHz enable
`define D0_DIV_6M 4

// 24 MHz positive ticks per 1HB enable
`define D0_DIV_1H 8

// Upper Z80 address bits [15:11] where work RAM begins, F800h
`define D0_RAM_BASE 5'b11111

`endif

//--- common/clockPkg.sv
/*
 * Clock enable types shared by the divider and the top level
 */
package clockPkg;

	// Single-cycle enables, all active high
	typedef struct packed {
		// 12 MHz rising phase
		logic ce12;
		// 12 MHz falling phase
		logic ce12N;
		// Main CPU clock rising phase
		logic ceCpuP;
		// Main CPU clock falling phase
		logic ceCpuN;
		// 6 MHz enable
		logic ce6;
		// 1HB enable
		logic ce1H;
	} clockEnables;

endpackage

//--- common/busPkg.sv
/*
 * Bus types for the sound CPU decoder and the host write latch
 */
`include "d0Settings_settings.svh"

package busPkg;

	// Z80 bus request as seen on the glue chip pins
	typedef struct packed {
		// Upper address bits, memory map decode
		logic [15:11] addrHi;
		// Lower address bits, I/O port decode
		logic [4:2]   addrLo;
		// Strobes, all active low
		logic         rd;
		logic         wr;
		logic         mreq;
		logic         iorq;
	} z80BusReq;

	// Chip selects toward the sound side, every line active low
	typedef struct packed {
		// Command latch read by the Z80
		logic cmdRead;
		// Reply latch write by the Z80
		logic replyWrite;
		// Command latch clear
		logic cmdClear;
		// Program ROM and memory strobes
		logic romCs;
		logic memRd;
		logic memWr;
		// FM chip
		logic fmCs;
		logic fmRd;
		logic fmWr;
		// Work RAM
		logic ramCs;
		// Interrupt request to the Z80
		logic nmi;
	} z80Selects;

	// Registers written by the main CPU
	typedef struct packed {
		logic [`D0_BANK_W-1:0] bank;
		logic [`D0_PORT_W-1:0] p1;
		logic [`D0_PORT_W-1:0] p2;
	} hostOutputs;

endpackage

//--- logic/clockDivider.sv
/*
 * Clock enable divider
 * Turns the 24 MHz enable pair into registered 12 MHz, CPU, 6 MHz and 1HB pulses
 */
`timescale 1ns/1ps
`include "d0Settings_settings.svh"

module clockDivider import clockPkg::*; (
	input  logic        CLK,
	input  logic        arstN,
	input  logic        ce24P,
	input  logic        ce24N,
	output clockEnables clocks
);

	// Counts 24 MHz positive phases, wraps every 8
	logic [2:0] tickCnt;
	// One bit wider so the wrap to zero is visible to the ratio checks
	logic [3:0] tickNext;
	// Set after a 12 MHz rising phase, cleared by the following ce24N
	logic       halfPending;
	// Ratio hits for the current ce24P
	logic       hit12;
	logic       hit6;
	logic       hit1H;

	assign tickNext = {1'b0, tickCnt} + 4'd1;

	// Every second tick, so the first one lands on the second ce24P
	assign hit12 = ~tickNext[0];

	// Slower enables on multiples of their ratio
	assign hit6  = (tickNext % 4'(`D0_DIV_6M)) == 4'd0;
	assign hit1H = (tickNext % 4'(`D0_DIV_1H)) == 4'd0;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			tickCnt     <= '0;
			halfPending <= 1'b0;
			clocks      <= '0;
		end else begin
			// Pulses last a single CLK
			clocks <= '0;

			if (ce24P) begin
				tickCnt       <= tickNext[2:0];
				clocks.ce12   <= hit12;
				clocks.ceCpuP <= hit12;
				clocks.ce6    <= hit6;
				clocks.ce1H   <= hit1H;
				// Falling half of the 12 MHz period is now owed
				if (hit12) begin
					halfPending <= 1'b1;
				end
			end

			// Falling phase follows on the next 24 MHz negative enable
			if (ce24N && halfPending) begin
				clocks.ce12N  <= 1'b1;
				clocks.ceCpuN <= 1'b1;
				halfPending   <= 1'b0;
			end
		end
	end

endmodule

//--- z80Decode/z80Decode.sv
/*
 * Sound CPU bus decoder
 * Memory and I/O port chip selects plus the NMI request flag
 */
`timescale 1ns/1ps
`include "d0Settings_settings.svh"

module z80Decode import busPkg::*; (
	input  logic      CLK,
	input  logic      arstN,
	input  z80BusReq  bus,
	input  logic      cmdStrobe,
	output z80Selects selects
);

	// Cycle type
	logic       memCycle;
	logic       ioCycle;
	// Strobes turned active high
	logic       rdActive;
	logic       wrActive;
	// Address at or above the work RAM base
	logic       ramArea;
	// Port number, bit 4 of the low address is not decoded
	logic [1:0] port;
	// Active-high port hits
	logic       cmdReadHit;
	logic       cmdClearHit;
	logic       fmHit;
	logic       nmiEnSet;
	logic       replyHit;
	// NMI state
	logic       nmiEn;
	logic       cmdStrobeD;
	logic       cmdFall;
	logic       nmiPending;

	assign memCycle = ~bus.mreq;
	assign ioCycle  = ~bus.iorq;
	assign rdActive = ~bus.rd;
	assign wrActive = ~bus.wr;
	assign ramArea  = bus.addrHi >= 5'(`D0_RAM_BASE);
	assign port     = bus.addrLo[3:2];

	// Port 0 is the command latch, read or clear
	assign cmdReadHit  = ioCycle && (port == 2'd0) && rdActive;
	assign cmdClearHit = ioCycle && (port == 2'd0) && wrActive;
	// Port 1 is the FM chip, either direction
	assign fmHit       = ioCycle && (port == 2'd1);
	// Port 2 write arms the NMI
	assign nmiEnSet    = ioCycle && (port == 2'd2) && wrActive;
	// Port 3 write goes to the reply latch and disarms the NMI
	assign replyHit    = ioCycle && (port == 2'd3) && wrActive;

	// Falling edge of the main CPU command write
	assign cmdFall = cmdStrobeD & ~cmdStrobe;

	always_comb begin
		// Everything idle high outside a decoded cycle
		selects = '1;

		// Memory map, ROM below the RAM base
		if (memCycle) begin
			selects.romCs = ramArea;
			selects.ramCs = ~ramArea;
			selects.memRd = bus.rd;
			selects.memWr = bus.wr;
		end

		selects.cmdRead    = ~cmdReadHit;
		selects.cmdClear   = ~cmdClearHit;
		selects.replyWrite = ~replyHit;

		// FM strobes only while its port is addressed
		if (fmHit) begin
			selects.fmCs = 1'b0;
			selects.fmRd = bus.rd;
			selects.fmWr = bus.wr;
		end

		selects.nmi = ~nmiPending;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			nmiEn      <= 1'b0;
			cmdStrobeD <= 1'b1;
			nmiPending <= 1'b0;
		end else begin
			cmdStrobeD <= cmdStrobe;

			// Arm and disarm from the Z80 side
			if (nmiEnSet) begin
				nmiEn <= 1'b1;
			end else if (replyHit) begin
				nmiEn <= 1'b0;
			end

			// A new command wins over a read of the old one
			if (cmdFall && nmiEn) begin
				nmiPending <= 1'b1;
			end else if (cmdReadHit) begin
				nmiPending <= 1'b0;
			end
		end
	end

endmodule

//--- logic/hostLatch.sv
/*
 * Host write latch
 * Loads the bank or the two port registers on a main CPU write strobe fall
 */
`timescale 1ns/1ps
`include "d0Settings_settings.svh"

module hostLatch import busPkg::*; (
	input  logic       CLK,
	input  logic       arstN,
	input  logic       wrStrobe,
	input  logic       addrSel,
	input  logic [5:0] data,
	output hostOutputs outputs
);

	// Strobe level from the previous CLK
	logic       wrStrobeD;
	// Registered falling edge, one CLK after the strobe drops
	logic       fallSeen;
	// Bus values taken while the strobe falls
	logic       addrSelQ;
	logic [5:0] dataQ;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			wrStrobeD <= 1'b1;
			fallSeen  <= 1'b0;
		end else begin
			wrStrobeD <= wrStrobe;
			fallSeen  <= wrStrobeD & ~wrStrobe;
		end
	end

	// Hold address and data next to the edge flag
	always_ff @(posedge CLK) begin
		if (wrStrobeD && !wrStrobe) begin
			addrSelQ <= addrSel;
			dataQ    <= data;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			outputs <= '0;
		end else if (fallSeen) begin
			// A4 high selects the bank register
			if (addrSelQ) begin
				outputs.bank <= dataQ[`D0_BANK_W-1:0];
			end else begin
				// Low half to P1, high half to P2
				outputs.p1 <= dataQ[`D0_PORT_W-1:0];
				outputs.p2 <= dataQ[2*`D0_PORT_W-1:`D0_PORT_W];
			end
		end
	end

endmodule

//--- logic/soundGlue.sv
/*
 * Sound glue chip top level
 * Enable divider, Z80 decoder and host latch on one clock
 */
`timescale 1ns/1ps

module soundGlue import clockPkg::*, busPkg::*; (
	input  logic        CLK,
	input  logic        arstN,
	// 24 MHz enable pair from outside
	input  logic        ce24P,
	input  logic        ce24N,
	// Sound CPU bus
	input  z80BusReq    bus,
	// Main CPU command write, active low
	input  logic        cmdStrobe,
	// Main CPU register write
	input  logic        wrStrobe,
	input  logic        addrSel,
	input  logic [5:0]  data,
	// Divided enables
	output clockEnables clocks,
	// Sound side selects
	output z80Selects   selects,
	// Bank and port registers
	output hostOutputs  outputs
);

	// Divided single-cycle enables
	clockDivider clockDivider_inst (
		.CLK    (CLK),
		.arstN  (arstN),
		.ce24P  (ce24P),
		.ce24N  (ce24N),
		.clocks (clocks)
	);

	// Chip selects and NMI
	z80Decode z80Decode_inst (
		.CLK       (CLK),
		.arstN     (arstN),
		.bus       (bus),
		.cmdStrobe (cmdStrobe),
		.selects   (selects)
	);

	// Bank and port registers from the main side
	hostLatch hostLatch_inst (
		.CLK      (CLK),
		.arstN    (arstN),
		.wrStrobe (wrStrobe),
		.addrSel  (addrSel),
		.data     (data),
		.outputs  (outputs)
	);

endmodule

//--- verification/soundGlueTb.sv
/*
 * Sound glue chip testbench
 * Reset state, enable ratios, Z80 decode, NMI flag and host latch from a stimulus table
 */
`timescale 1ns/1ps
`include "d0Settings_settings.svh"

module soundGlueTb
	import clockPkg::*, busPkg::*;
();

	// Row kinds
	localparam logic [1:0] kindMem  = 2'd0;
	localparam logic [1:0] kindIo   = 2'd1;
	localparam logic [1:0] kindCmd  = 2'd2;
	localparam logic [1:0] kindHost = 2'd3;

	// Strobe sets {rd, wr, mreq, iorq}, all active low
	localparam logic [3:0] memRead  = 4'b0101;
	localparam logic [3:0] memWrite = 4'b1001;
	localparam logic [3:0] ioRead   = 4'b0110;
	localparam logic [3:0] ioWrite  = 4'b1010;
	localparam logic [3:0] rdOnly   = 4'b0111;
	localparam logic [3:0] noCycle  = 4'b1111;

	// Lines expected low, in z80Selects bit order
	localparam logic [10:0] selCmdRd  = 11'h400;
	localparam logic [10:0] selReply  = 11'h200;
	localparam logic [10:0] selCmdClr = 11'h100;
	localparam logic [10:0] selRom    = 11'h080;
	localparam logic [10:0] selMemRd  = 11'h040;
	localparam logic [10:0] selMemWr  = 11'h020;
	localparam logic [10:0] selFmCs   = 11'h010;
	localparam logic [10:0] selFmRd   = 11'h008;
	localparam logic [10:0] selFmWr   = 11'h004;
	localparam logic [10:0] selRam    = 11'h002;
	localparam logic [10:0] selNmi    = 11'h001;
	localparam logic [10:0] selNone   = 11'h000;

	// 24 MHz positive pulses in the ratio test
	localparam int pulses         = 64;
	localparam int numRows        = 23;
	// Host latch rows sit at the end of the table
	localparam int hostBase       = 19;
	localparam int watchdogCycles = numRows * 20 + 200;

	// One table entry
	typedef struct packed {
		logic [1:0] kind;
		z80BusReq   bus;
		logic       cmdLow;
		logic       addrSel;
		logic [5:0] data;
		z80Selects  expSel;
		hostOutputs expOut;
	} testRow;

	logic        CLK = 1'b0;
	logic        arstN;
	logic        ce24P;
	logic        ce24N;
	z80BusReq    bus;
	logic        cmdStrobe;
	logic        wrStrobe;
	logic        addrSel;
	logic [5:0]  data;
	clockEnables clocks;
	z80Selects   selects;
	hostOutputs  outputs;
	testRow      rows [numRows];

	soundGlue soundGlue_inst (
		.CLK       (CLK),
		.arstN     (arstN),
		.ce24P     (ce24P),
		.ce24N     (ce24N),
		.bus       (bus),
		.cmdStrobe (cmdStrobe),
		.wrStrobe  (wrStrobe),
		.addrSel   (addrSel),
		.data      (data),
		.clocks    (clocks),
		.selects   (selects),
		.outputs   (outputs)
	);

	// 100 MHz
	always #5 CLK = ~CLK;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Bus or command row, bus fields packed as {addrHi, addrLo, strobes}
	function automatic testRow busRow(input logic [1:0] kind, input logic [4:0] addrHi,
			input logic [1:0] port, input logic [3:0] strobes, input logic cmdLow,
			input logic [10:0] lowMask);
		testRow r;
		r.kind    = kind;
		r.bus     = z80BusReq'({addrHi, 1'b0, port, strobes});
		r.cmdLow  = cmdLow;
		r.addrSel = 1'b0;
		r.data    = '0;
		r.expSel  = z80Selects'(~lowMask);
		r.expOut  = '0;
		return r;
	endfunction

	task automatic buildTable();
		logic [31:0] seed;
		hostOutputs  model;
		testRow      r;
		// Memory map, ROM below F800h and RAM from there up
		rows[0]  = busRow(kindMem, 5'h00, 2'd0, memRead, 1'b0, selRom | selMemRd);
		rows[1]  = busRow(kindMem, 5'h1e, 2'd0, memWrite, 1'b0, selRom | selMemWr);
		rows[2]  = busRow(kindMem, 5'h1f, 2'd0, memRead, 1'b0, selRam | selMemRd);
		rows[3]  = busRow(kindMem, 5'h1f, 2'd0, memWrite, 1'b0, selRam | selMemWr);
		rows[4]  = busRow(kindMem, 5'h1f, 2'd0, rdOnly, 1'b0, selNone);
		// I/O ports
		rows[5]  = busRow(kindIo, 5'h00, 2'd0, ioRead, 1'b0, selCmdRd);
		rows[6]  = busRow(kindIo, 5'h00, 2'd0, ioWrite, 1'b0, selCmdClr);
		rows[7]  = busRow(kindIo, 5'h00, 2'd1, ioRead, 1'b0, selFmCs | selFmRd);
		rows[8]  = busRow(kindIo, 5'h00, 2'd1, ioWrite, 1'b0, selFmCs | selFmWr);
		rows[9]  = busRow(kindIo, 5'h00, 2'd3, ioWrite, 1'b0, selReply);
		rows[10] = busRow(kindIo, 5'h00, 2'd3, ioRead, 1'b0, selNone);
		// NMI disarmed, then armed, raised and cleared by a command read
		rows[11] = busRow(kindCmd, 5'h00, 2'd0, noCycle, 1'b1, selNone);
		rows[12] = busRow(kindIo, 5'h00, 2'd2, ioWrite, 1'b0, selNone);
		rows[13] = busRow(kindCmd, 5'h00, 2'd0, noCycle, 1'b1, selNmi);
		rows[14] = busRow(kindIo, 5'h00, 2'd0, ioRead, 1'b0, selCmdRd);
		rows[15] = busRow(kindCmd, 5'h00, 2'd0, noCycle, 1'b1, selNmi);
		rows[16] = busRow(kindIo, 5'h00, 2'd0, ioRead, 1'b0, selCmdRd);
		// Reply write disarms, so the next command leaves nmi high
		rows[17] = busRow(kindIo, 5'h00, 2'd3, ioWrite, 1'b0, selReply);
		rows[18] = busRow(kindCmd, 5'h00, 2'd0, noCycle, 1'b1, selNone);
		// Host writes alternate bank and port pair with random data
		seed  = 32'hcce8;
		model = '0;
		for (int j = 0; j < numRows - hostBase; j++) begin
			seed      = xorshift(seed);
			r         = busRow(kindHost, 5'h00, 2'd0, noCycle, 1'b0, selNone);
			r.addrSel = (j % 2 == 0);
			r.data    = seed[5:0];
			if (r.addrSel) begin
				model.bank = r.data[`D0_BANK_W-1:0];
			end else begin
				model.p1 = r.data[`D0_PORT_W-1:0];
				model.p2 = r.data[2*`D0_PORT_W-1:`D0_PORT_W];
			end
			r.expOut = model;
			rows[hostBase + j] = r;
		end
	endtask

	task automatic reportMismatch(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "check failed");
	endtask

	task automatic checkSelects(input z80Selects got, input z80Selects want, input string what);
		if (got !== want) begin
			reportMismatch($sformatf("%s selects %b, expected %b", what, got, want));
		end
	endtask

	task automatic checkOutputs(input hostOutputs got, input hostOutputs want,
			input string what);
		if (got !== want) begin
			reportMismatch($sformatf("%s outputs %h, expected %h", what, got, want));
		end
	endtask

	task automatic checkClocks(input clockEnables got, input clockEnables want,
			input string what);
		if (got !== want) begin
			reportMismatch($sformatf("%s enables %b, expected %b", what, got, want));
		end
	endtask

	task automatic checkCount(input string what, input int got, input int want);
		if (got != want) begin
			reportMismatch($sformatf("%s count %0d, expected %0d", what, got, want));
		end
	endtask

	// Bus idle, strobes released
	task automatic driveIdle();
		bus       <= z80BusReq'({5'h00, 3'd0, noCycle});
		cmdStrobe <= 1'b1;
		wrStrobe  <= 1'b1;
	endtask

	task automatic applyRow(input testRow r);
		bus       <= r.bus;
		cmdStrobe <= ~r.cmdLow;
		if (r.kind == kindHost) begin
			wrStrobe <= 1'b0;
			addrSel  <= r.addrSel;
			data     <= r.data;
		end
	endtask

	initial begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Timeout: the test sequence did not finish in time");
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int  n12;
		int  n12N;
		int  nCpuP;
		int  nCpuN;
		int  n6;
		int  n1H;
		logic owed;
		arstN   <= 1'b0;
		ce24P   <= 1'b0;
		ce24N   <= 1'b0;
		addrSel <= 1'b0;
		data    <= '0;
		driveIdle();
		buildTable();
		repeat (4) @(posedge CLK);
		arstN <= 1'b1;

		// Reset state before any 24 MHz pulse
		@(posedge CLK);
		@(negedge CLK);
		checkClocks(clocks, '0, "after reset");
		checkSelects(selects, '1, "after reset");
		checkOutputs(outputs, '0, "after reset");

		// Alternating ce24P and ce24N, then a few cycles to drain
		n12   = 0;
		n12N  = 0;
		nCpuP = 0;
		nCpuN = 0;
		n6    = 0;
		n1H   = 0;
		owed  = 1'b0;
		for (int i = 0; i < 2 * pulses + 4; i++) begin
			@(posedge CLK);
			ce24P <= (i < 2 * pulses) && (i % 2 == 0);
			ce24N <= (i < 2 * pulses) && (i % 2 == 1);
			@(negedge CLK);
			if (clocks.ce12) begin
				if (owed) begin
					reportMismatch("two ce12 pulses without a ce12N between them");
				end
				owed = 1'b1;
				n12++;
			end
			if (clocks.ce12N) begin
				owed = 1'b0;
				n12N++;
			end
			if (clocks.ceCpuP) begin
				nCpuP++;
			end
			if (clocks.ceCpuN) begin
				nCpuN++;
			end
			if (clocks.ce6) begin
				n6++;
			end
			if (clocks.ce1H) begin
				n1H++;
			end
		end
		checkCount("ce12", n12, pulses / 2);
		checkCount("ce12N", n12N, pulses / 2);
		checkCount("ceCpuP", nCpuP, pulses / 2);
		checkCount("ceCpuN", nCpuN, pulses / 2);
		checkCount("ce6", n6, pulses / `D0_DIV_6M);
		checkCount("ce1H", n1H, pulses / `D0_DIV_1H);

		// Table rows, each checked two cycles after its stimulus
		for (int i = 0; i < numRows; i++) begin
			@(posedge CLK);
			applyRow(rows[i]);
			@(posedge CLK);
			@(posedge CLK);
			@(negedge CLK);
			if (rows[i].kind == kindHost) begin
				checkOutputs(outputs, rows[i].expOut, $sformatf("row %0d", i));
			end else begin
				checkSelects(selects, rows[i].expSel, $sformatf("row %0d", i));
			end
			@(posedge CLK);
			driveIdle();
		end

		$display("Regression passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+common
common/clockPkg.sv
common/busPkg.sv
logic/clockDivider.sv
z80Decode/z80Decode.sv
logic/hostLatch.sv
logic/soundGlue.sv
verification/soundGlueTb.sv

//--- run.sh
#!/bin/sh
# Builds the sound glue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module soundGlueTb -Mdir obj_dir -o soundGlueSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/soundGlueSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
